/* Bender.yml */
package:
  name: exe_unit

sources:
  - files:
      - verilog/exe_pkg.sv
      - verilog/op_queue.sv
      - verilog/int_alu.sv
      - verilog/branch_unit.sv
      - verilog/result_merge.sv
      - verilog/exe_unit.sv
  - target: simulation
    files:
      - sim/tb_exe_unit.sv

/* sim.f */
verilog/exe_pkg.sv
verilog/op_queue.sv
verilog/int_alu.sv
verilog/branch_unit.sv
verilog/result_merge.sv
verilog/exe_unit.sv
sim/tb_exe_unit.sv

/* sim/tb_exe_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_exe_unit;

    import exe_pkg::*;

    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned OUT_CREDITS = 2;
    localparam int ISSUE_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 400;

    logic        clk;
    logic        rst;
    logic        op_valid_i;
    exe_op_t     op_i;
    logic        res_credit_i;
    logic        op_credit_o;
    logic        res_valid_o;
    exe_result_t res_o;

    exe_op_t     op_table[$];
    exe_result_t exp_table[$];

    int errors;
    int timeouts;
    int checked_cnt;
    int op_credit_cnt;
    int up_credits;
    int seed;

    exe_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .res_credit_i (res_credit_i),
        .op_credit_o  (op_credit_o),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // helpers

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input exe_opcode_e opc, input word_t a, input word_t b,
                           input word_t imm, input word_t pc, input reg_addr_t rd,
                           input logic we, input word_t wdata, input logic redirect,
                           input word_t target);
        exe_op_t     op;
        exe_result_t res;
        op.opcode    = opc;
        op.a         = a;
        op.b         = b;
        op.imm       = imm;
        op.pc        = pc;
        op.rd        = rd;
        res.rd       = rd;
        res.rd_we    = we;
        res.wdata    = wdata;
        res.redirect = redirect;
        res.target   = target;
        op_table.push_back(op);
        exp_table.push_back(res);
    endtask

    // one upstream cycle that also collects a returned credit
    task automatic upstream_cycle();
        @(negedge clk);
        op_valid_i = 1'b0;
        if (op_credit_o === 1'b1) begin
            up_credits++;
            op_credit_cnt++;
        end
        if (up_credits > QUEUE_DEPTH) begin
            check_value("upstream credits", up_credits, QUEUE_DEPTH);
        end
    endtask

    task automatic build_table();
        // alu group with pc and imm zero so target is zero
        add_row(OP_ADD, 32'd5, 32'd7, 0, 0, 5'd1, 1, 32'd12, 0, 0);
        add_row(OP_SUB, 32'd3, 32'd5, 0, 0, 5'd2, 1, 32'hffff_fffe, 0, 0);
        add_row(OP_AND, 32'hf0f0_00ff, 32'h0ff0_0f0f, 0, 0, 5'd3, 1, 32'h00f0_000f, 0, 0);
        add_row(OP_OR, 32'hf0f0_00ff, 32'h0ff0_0f0f, 0, 0, 5'd4, 1, 32'hfff0_0fff, 0, 0);
        add_row(OP_XOR, 32'hf0f0_00ff, 32'h0ff0_0f0f, 0, 0, 5'd5, 1, 32'hff00_0ff0, 0, 0);
        add_row(OP_SLT, 32'hffff_ffff, 32'd1, 0, 0, 5'd6, 1, 32'd1, 0, 0);
        add_row(OP_SLT, 32'd1, 32'hffff_ffff, 0, 0, 5'd6, 1, 32'd0, 0, 0);
        add_row(OP_SLTU, 32'hffff_ffff, 32'd1, 0, 0, 5'd7, 1, 32'd0, 0, 0);
        add_row(OP_SLTU, 32'd1, 32'hffff_ffff, 0, 0, 5'd7, 1, 32'd1, 0, 0);
        // shift amounts take only the low 5 bits of b
        add_row(OP_SLL, 32'd1, 32'h24, 0, 0, 5'd8, 1, 32'h10, 0, 0);
        add_row(OP_SRL, 32'h8000_0000, 32'd4, 0, 0, 5'd9, 1, 32'h0800_0000, 0, 0);
        add_row(OP_SRA, 32'h8000_0000, 32'd4, 0, 0, 5'd10, 1, 32'hf800_0000, 0, 0);
        add_row(OP_SRA, 32'h7000_0000, 32'h3c, 0, 0, 5'd11, 1, 32'd7, 0, 0);
        add_row(OP_ADD, 32'd1, 32'd2, 0, 0, 5'd0, 0, 32'd3, 0, 0);
        // branches all target 0x100 + 0x20
        add_row(OP_BEQ, 32'd9, 32'd9, 32'h20, 32'h100, 5'd5, 0, 0, 1, 32'h120);
        add_row(OP_BEQ, 32'd9, 32'd8, 32'h20, 32'h100, 5'd5, 0, 0, 0, 32'h120);
        add_row(OP_BNE, 32'd9, 32'd8, 32'h20, 32'h100, 5'd5, 0, 0, 1, 32'h120);
        add_row(OP_BNE, 32'd9, 32'd9, 32'h20, 32'h100, 5'd5, 0, 0, 0, 32'h120);
        add_row(OP_BLT, 32'hffff_fffe, 32'd1, 32'h20, 32'h100, 5'd5, 0, 0, 1, 32'h120);
        add_row(OP_BLT, 32'd1, 32'hffff_fffe, 32'h20, 32'h100, 5'd5, 0, 0, 0, 32'h120);
        add_row(OP_BGE, 32'd5, 32'd5, 32'h20, 32'h100, 5'd5, 0, 0, 1, 32'h120);
        add_row(OP_BGE, 32'hffff_fffe, 32'd1, 32'h20, 32'h100, 5'd5, 0, 0, 0, 32'h120);
        add_row(OP_BLTU, 32'd1, 32'hffff_fffe, 32'h20, 32'h100, 5'd5, 0, 0, 1, 32'h120);
        add_row(OP_BLTU, 32'hffff_fffe, 32'd1, 32'h20, 32'h100, 5'd5, 0, 0, 0, 32'h120);
        add_row(OP_BGEU, 32'hffff_fffe, 32'd1, 32'h20, 32'h100, 5'd5, 0, 0, 1, 32'h120);
        add_row(OP_BGEU, 32'd3, 32'd3, 32'h20, 32'h100, 5'd5, 0, 0, 1, 32'h120);
        add_row(OP_BGEU, 32'd1, 32'hffff_fffe, 32'h20, 32'h100, 5'd5, 0, 0, 0, 32'h120);
        // jump back 16 bytes with link at pc + 4
        add_row(OP_JAL, 0, 0, 32'hffff_fff0, 32'h200, 5'd1, 1, 32'h204, 1, 32'h1f0);
    endtask

    // --------------------
    // result checker

    always @(posedge clk) begin
        if (!rst && res_valid_o === 1'b1) begin
            if (checked_cnt >= exp_table.size()) begin
                $display("error %0t: result beyond the end of the table", $time);
                errors++;
            end else begin
                check_value("rd", res_o.rd, exp_table[checked_cnt].rd);
                check_value("rd_we", res_o.rd_we, exp_table[checked_cnt].rd_we);
                check_value("wdata", res_o.wdata, exp_table[checked_cnt].wdata);
                check_value("redirect", res_o.redirect, exp_table[checked_cnt].redirect);
                check_value("target", res_o.target, exp_table[checked_cnt].target);
            end
            checked_cnt++;
        end
    end

    // --------------------
    // downstream consumer

    initial begin : consumer
        int received;
        int returned;
        int gap;
        bit stalled;
        res_credit_i = 1'b0;
        received     = 0;
        returned     = 0;
        gap          = 0;
        stalled      = 1'b0;
        seed         = 32'hb56e_0eda;
        forever begin
            @(negedge clk);
            res_credit_i = 1'b0;
            if (res_valid_o === 1'b1) begin
                received++;
            end
            if (received - returned > OUT_CREDITS) begin
                check_value("results outstanding", received - returned, OUT_CREDITS);
            end
            // hold all credits for a while so the queue backs up
            if (!stalled && received >= 6) begin
                stalled = 1'b1;
                gap     = 40;
            end
            if (gap > 0) begin
                gap--;
            end else if (received > returned) begin
                res_credit_i = 1'b1;
                returned++;
                gap = $random(seed) & 3;
            end
        end
    end

    // --------------------
    // reset, issue and drain

    initial begin : main
        int row;
        int waited;
        rst           = 1'b1;
        op_valid_i    = 1'b0;
        op_i          = '0;
        errors        = 0;
        timeouts      = 0;
        checked_cnt   = 0;
        op_credit_cnt = 0;
        up_credits    = QUEUE_DEPTH;
        build_table();

        repeat (3) @(negedge clk);
        rst = 1'b0;

        // outputs must stay quiet before anything is issued
        repeat (4) begin
            @(negedge clk);
            check_value("idle res_valid_o", res_valid_o, 1'b0);
            check_value("idle op_credit_o", op_credit_o, 1'b0);
        end

        row    = 0;
        waited = 0;
        while (row < op_table.size() && waited < ISSUE_TIMEOUT) begin
            upstream_cycle();
            if (up_credits > 0) begin
                op_valid_i = 1'b1;
                op_i       = op_table[row];
                up_credits--;
                row++;
                waited = 0;
            end else begin
                waited++;
            end
        end
        if (row < op_table.size()) begin
            $display("timeout: upstream credits never came back at row %0d", row);
            timeouts++;
        end

        waited = 0;
        while (checked_cnt < exp_table.size() && waited < DRAIN_TIMEOUT) begin
            upstream_cycle();
            waited++;
        end
        if (checked_cnt < exp_table.size()) begin
            $display("timeout: only %0d of %0d results arrived", checked_cnt,
                     exp_table.size());
            timeouts++;
        end

        // let the last credit pulse and any stray result show up
        repeat (4) upstream_cycle();
        check_value("result count", checked_cnt, exp_table.size());
        check_value("op credit pulses", op_credit_cnt, checked_cnt);
        check_value("final upstream credits", up_credits, QUEUE_DEPTH);

        $display("results %0d, errors %0d, timeouts %0d", checked_cnt, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  exe_pkg::exe_op_t    op_i,
    output exe_pkg::branch_out_t br_o
);

    import exe_pkg::*;

    logic bc_uns;
    logic bc_a_eq_b;
    logic bc_a_lt_b;
    logic is_branch;
    logic is_jump;
    logic taken;

    // --------------------
    // branch compare

    assign bc_uns    = (op_i.opcode == OP_BLTU) || (op_i.opcode == OP_BGEU);
    assign bc_a_eq_b = (op_i.a == op_i.b);
    assign bc_a_lt_b = bc_uns ? (op_i.a < op_i.b) :
                                ($signed(op_i.a) < $signed(op_i.b));

    // --------------------
    // resolution

    assign is_branch = op_i.opcode inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    assign is_jump   = (op_i.opcode == OP_JAL);

    always_comb begin
        taken = 1'b0;
        case (op_i.opcode)
            OP_BEQ:  taken = bc_a_eq_b;
            OP_BNE:  taken = !bc_a_eq_b;
            OP_BLT:  taken = bc_a_lt_b;
            OP_BGE:  taken = !bc_a_lt_b;
            OP_BLTU: taken = bc_a_lt_b;
            OP_BGEU: taken = !bc_a_lt_b;
            // jal never falls through
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // target and link are pc relative
    assign br_o.is_ctrl = is_branch || is_jump;
    assign br_o.taken   = taken;
    assign br_o.target  = op_i.pc + op_i.imm;
    assign br_o.link    = op_i.pc + word_t'(4);

endmodule

`default_nettype wire

/* verilog/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    // --------------------
    // widths and basic types

    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // --------------------
    // operation codes

    typedef enum logic [4:0] {
        // integer alu group
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_AND  = 5'd2,
        OP_OR   = 5'd3,
        OP_XOR  = 5'd4,
        OP_SLT  = 5'd5,
        OP_SLTU = 5'd6,
        OP_SLL  = 5'd7,
        OP_SRL  = 5'd8,
        OP_SRA  = 5'd9,
        // conditional branches
        OP_BEQ  = 5'd10,
        OP_BNE  = 5'd11,
        OP_BLT  = 5'd12,
        OP_BGE  = 5'd13,
        OP_BLTU = 5'd14,
        OP_BGEU = 5'd15,
        // unconditional jump with link
        OP_JAL  = 5'd16
    } exe_opcode_e;

    // --------------------
    // packets between the blocks

    // one operation entering the execute slice
    typedef struct packed {
        exe_opcode_e opcode;
        word_t       a;
        word_t       b;
        word_t       imm;
        word_t       pc;
        reg_addr_t   rd;
    } exe_op_t;

    // branch unit view of the same operation
    typedef struct packed {
        logic  is_ctrl;
        logic  taken;
        word_t target;
        word_t link;
    } branch_out_t;

    // registered result toward writeback and fetch
    typedef struct packed {
        reg_addr_t rd;
        logic      rd_we;
        word_t     wdata;
        logic      redirect;
        word_t     target;
    } exe_result_t;

endpackage

`default_nettype wire

/* verilog/exe_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_unit #(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter int unsigned OUT_CREDITS = 2
)(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  op_valid_i,
    input  exe_pkg::exe_op_t      op_i,
    input  logic                  res_credit_i,
    output logic                  op_credit_o,
    output logic                  res_valid_o,
    output exe_pkg::exe_result_t  res_o
);

    import exe_pkg::*;

    logic        head_valid;
    exe_op_t     head;
    word_t       alu_result;
    branch_out_t br_out;
    logic        pop;

    op_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) op_queue_i (
        .clk          (clk),
        .rst          (rst),
        .push_i       (op_valid_i),
        .op_i         (op_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head),
        .credit_o     (op_credit_o)
    );

    // alu and branch unit both see the queue head
    int_alu int_alu_i (
        .op_i     (head),
        .result_o (alu_result)
    );

    branch_unit branch_unit_i (
        .op_i (head),
        .br_o (br_out)
    );

    result_merge #(
        .OUT_CREDITS (OUT_CREDITS)
    ) result_merge_i (
        .clk          (clk),
        .rst          (rst),
        .head_valid_i (head_valid),
        .head_i       (head),
        .alu_result_i (alu_result),
        .br_i         (br_out),
        .res_credit_i (res_credit_i),
        .pop_o        (pop),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o)
    );

endmodule

`default_nettype wire

/* verilog/int_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    input  exe_pkg::exe_op_t op_i,
    output exe_pkg::word_t   result_o
);

    import exe_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    word_t      result;

    // only the low bits of b count as the shift amount
    assign shamt = op_i.b[4:0];

    assign lt_signed   = ($signed(op_i.a) < $signed(op_i.b));
    assign lt_unsigned = (op_i.a < op_i.b);

    // --------------------
    // result select

    always_comb begin
        result = '0;
        case (op_i.opcode)
            OP_ADD: begin
                result = op_i.a + op_i.b;
            end
            OP_SUB: begin
                result = op_i.a - op_i.b;
            end
            OP_AND: begin
                result = op_i.a & op_i.b;
            end
            OP_OR: begin
                result = op_i.a | op_i.b;
            end
            OP_XOR: begin
                result = op_i.a ^ op_i.b;
            end
            OP_SLT: begin
                result = {{(xlen-1){1'b0}}, lt_signed};
            end
            OP_SLTU: begin
                result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            OP_SLL: begin
                result = op_i.a << shamt;
            end
            OP_SRL: begin
                result = op_i.a >> shamt;
            end
            OP_SRA: begin
                result = word_t'($signed(op_i.a) >>> shamt);
            end
            // branches and jal produce nothing here
            default: begin
                result = '0;
            end
        endcase
    end

    assign result_o = result;

endmodule

`default_nettype wire

/* verilog/op_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module op_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
)(
    input  logic              clk,
    input  logic              rst,
    input  logic              push_i,
    input  exe_pkg::exe_op_t  op_i,
    input  logic              pop_i,
    output logic              head_valid_o,
    output exe_pkg::exe_op_t  head_o,
    output logic              credit_o
);

    import exe_pkg::*;

    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    exe_op_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               credit_q;

    // --------------------
    // storage

    // no full check, the sender only pushes while holding a credit
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= op_i;
        end
    end

    // --------------------
    // pointers and occupancy

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one credit back upstream per entry that left
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_q <= 1'b0;
        end else begin
            credit_q <= pop_i;
        end
    end

    assign head_valid_o = (count != '0);
    assign head_o       = mem[rd_ptr];
    assign credit_o     = credit_q;

endmodule

`default_nettype wire

/* verilog/result_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module result_merge #(
    parameter int unsigned OUT_CREDITS = 2
)(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  head_valid_i,
    input  exe_pkg::exe_op_t      head_i,
    input  exe_pkg::word_t        alu_result_i,
    input  exe_pkg::branch_out_t  br_i,
    input  logic                  res_credit_i,
    output logic                  pop_o,
    output logic                  res_valid_o,
    output exe_pkg::exe_result_t  res_o
);

    import exe_pkg::*;

    localparam int unsigned CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic             pop;
    logic             is_alu;
    logic             is_jal;
    exe_result_t      res_next;
    exe_result_t      res_q;
    logic             res_valid_q;

    // --------------------
    // downstream credits

    // a send and a returned credit in one cycle cancel out
    assign pop = head_valid_i && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({pop, res_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // --------------------
    // result packet

    assign is_alu = head_i.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                          OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA};
    assign is_jal = (head_i.opcode == OP_JAL);

    always_comb begin
        res_next.rd       = head_i.rd;
        // x0 is never written
        res_next.rd_we    = (is_alu || is_jal) && (head_i.rd != '0);
        res_next.wdata    = is_jal ? br_i.link : alu_result_i;
        res_next.redirect = br_i.is_ctrl && br_i.taken;
        res_next.target   = br_i.target;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res_q <= res_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= pop;
        end
    end

    assign pop_o       = pop;
    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

`default_nettype wire
